// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module exTb -f all.f
	./obj_dir/VexTb | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
+incdir+verification
hdl/exPkg.sv
hdl/exStage1.sv
hdl/exMulUnit.sv
hdl/exStage2.sv
hdl/exStage3.sv
hdl/exTop.sv
verification/exTb.sv

// ==== hdl/exMulUnit.sv ====
/* 32x32 unsigned multiply of the low source halves. Product is valid mulHoldCycles
   edges after the EX2-to-EX3 edge; mulHoldCycles must be at least 1 */
`timescale 1ns/10ps

module exMulUnit import exPkg::*; #(
	parameter int mulHoldCycles = 2
) (
	input logic clock,
	input logic rstN,
	input logic hold,
	input logic mulStart,	// EX2 holds a MUL
	input regVal srcA,
	input regVal srcB,
	output regVal mulRes
);

	logic [31:0] ppLL, ppLH, ppHL, ppHH;	// 16x16 partial products
	regVal ppSum;
	regVal sumChain [mulHoldCycles];	// Free-running delay chain

	// Partials load with the EX2-to-EX3 move
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			ppLL <= '0;
			ppLH <= '0;
			ppHL <= '0;
			ppHH <= '0;
		end else if (mulStart && !hold) begin
			ppLL <= srcA[15:0] * srcB[15:0];
			ppLH <= srcA[15:0] * srcB[31:16];
			ppHL <= srcA[31:16] * srcB[15:0];
			ppHH <= srcA[31:16] * srcB[31:16];
		end
	end

	assign ppSum = {32'b0, ppLL} + {16'b0, ppLH, 16'b0} + {16'b0, ppHL, 16'b0}
		+ {ppHH, 32'b0};	// Align and add

	// Keeps moving through the EX3 hold
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < mulHoldCycles; i++)
				sumChain[i] <= '0;
		end else begin
			sumChain[0] <= ppSum;
			for (int i = 1; i < mulHoldCycles; i++)
				sumChain[i] <= sumChain[i-1];
		end
	end

	assign mulRes = sumChain[mulHoldCycles-1];	// Final once EX3 stops holding

endmodule

// ==== hdl/exPkg.sv ====
/* Types shared by the execute stages. Register 0 is the discard target and is never written;
   the memory status uses bit 1 as "not finished" but only 2'b10 stalls, 2'b11 retires as a fault */
package exPkg;

	// Micro-commands carried down the pipe
	typedef enum logic [3:0] {
		NOP,	// Bubble, writes nothing
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SHL,	// Resolved in EX2
		SHR,	// Logical, resolved in EX2
		MUL,	// Low 32 x low 32, unsigned
		LOAD,	// Address is A + imm
		STORE	// Data is B
	} uCmd;

	typedef logic [4:0] regId;	// Destination register number
	typedef logic [63:0] regVal;	// Data path width
	typedef logic [47:0] memAddrT;	// Sized like the core PC
	typedef logic [1:0] memStat;	// Memory answer

	localparam regId zeroReg = 5'd0;	// No write

	localparam memStat memReady = 2'b00;	// Access done
	localparam memStat memBusy = 2'b10;	// Still working, stall EX3
	localparam memStat memFault = 2'b11;	// Failed, retire without write

	// EX3 wait reason, tracked for checking
	typedef enum logic [1:0] {
		IDLEPASS,	// Passing through
		MEMWAIT,	// Stalled on memory
		MULWAIT	// Counting out the multiply
	} exState;

endpackage

// ==== hdl/exStage1.sv ====
/* EX1: simple ALU ops and the load/store address. Address is A + imm truncated
   to 48 bits, so sources must keep the sum below 2**48 */
`timescale 1ns/10ps

module exStage1 import exPkg::*; (
	input logic clock,
	input logic rstN,
	input logic hold,	// Freeze from EX3
	input logic opValid,
	input uCmd opCmd,
	input regVal srcA,
	input regVal srcB,
	input regVal imm,
	input regId dstId,
	output uCmd ex2Cmd,
	output regId ex2Id,
	output regVal ex2Val,
	output memAddrT ex2Addr,
	output regVal ex2SrcA,
	output regVal ex2SrcB
);

	uCmd cmdIn;	// Command after bubble insert
	regVal aluRes;	// EX1 result
	regVal addrSum;	// Full width so overflow is visible

	assign cmdIn = opValid ? opCmd : NOP;	// Invalid slot becomes a bubble
	assign addrSum = srcA + imm;

	always_comb begin
		case (cmdIn)
			ADD: aluRes = srcA + srcB;
			SUB: aluRes = srcA - srcB;
			AND: aluRes = srcA & srcB;
			OR: aluRes = srcA | srcB;
			XOR: aluRes = srcA ^ srcB;
			default: aluRes = '0;	// Filled in by later stages
		endcase
	end

	// Control half of the EX1/EX2 register
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			ex2Cmd <= NOP;
			ex2Id <= zeroReg;
		end else if (!hold) begin
			ex2Cmd <= cmdIn;
			ex2Id <= opValid ? dstId : zeroReg;	// Bubble writes nothing
		end
	end

	// Payload half
	always_ff @(posedge clock) begin
		if (!hold) begin
			ex2Val <= aluRes;
			ex2Addr <= addrSum[47:0];
			ex2SrcA <= srcA;	// Shifter and multiplier want raw sources
			ex2SrcB <= srcB;	// Also the store data
		end
	end

	// A memory address must not wrap past the 48-bit space
	addrFits: assert property (@(posedge clock) disable iff (!rstN)
		(!hold && (cmdIn == LOAD || cmdIn == STORE)) |-> (addrSum[63:48] == '0))
		else $error("EX1 address overflows memAddrT");

endmodule

// ==== hdl/exStage2.sv ====
/* EX2: 64-bit shifts by the low 6 bits of B and store-data capture.
   Shift right is logical only */
`timescale 1ns/10ps

module exStage2 import exPkg::*; (
	input logic clock,
	input logic rstN,
	input logic hold,
	input uCmd ex2Cmd,
	input regId ex2Id,
	input regVal ex2Val,
	input memAddrT ex2Addr,
	input regVal ex2SrcA,
	input regVal ex2SrcB,
	output uCmd ex3Cmd,
	output regId ex3Id,
	output regVal ex3Val,
	output memAddrT ex3Addr,
	output regVal ex3StoreData
);

	logic [5:0] shAmt;	// Shift count
	regVal stageVal;	// EX1 value or shift result

	assign shAmt = ex2SrcB[5:0];

	always_comb begin
		case (ex2Cmd)
			SHL: stageVal = ex2SrcA << shAmt;
			SHR: stageVal = ex2SrcA >> shAmt;
			default: stageVal = ex2Val;	// Pass EX1 result along
		endcase
	end

	// Control half of the EX2/EX3 register
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			ex3Cmd <= NOP;
			ex3Id <= zeroReg;
		end else if (!hold) begin
			ex3Cmd <= ex2Cmd;
			ex3Id <= ex2Id;
		end
	end

	// Payload half
	always_ff @(posedge clock) begin
		if (!hold) begin
			ex3Val <= stageVal;
			ex3Addr <= ex2Addr;
			ex3StoreData <= ex2SrcB;	// B is the store value
		end
	end

endmodule

// ==== hdl/exStage3.sv ====
/* EX3: final writeback select, memory stall and fault, counted multiply hold, flush.
   Memory outputs are levels while the op sits here; a flush retires at once */
`timescale 1ns/10ps

module exStage3 import exPkg::*; #(
	parameter int mulHoldCycles = 2
) (
	input logic clock,
	input logic rstN,
	input uCmd ex3Cmd,
	input regId ex3Id,
	input regVal ex3Val,
	input memAddrT ex3Addr,
	input regVal ex3StoreData,
	input regVal mulRes,
	input logic opBraFlush,
	input memStat memStatus,
	input regVal memRData,
	output logic exHold,
	output regId wbId,
	output regVal wbVal,
	output logic memReq,
	output logic memWrite,
	output memAddrT memAddr,
	output regVal memWData,
	output logic memFaultSeen
);

	localparam int cntW = $clog2(mulHoldCycles + 2);
	localparam logic [cntW-1:0] holdMax = cntW'(mulHoldCycles);

	logic [cntW-1:0] holdCnt;	// Saturating hold-cycle count
	logic isLoad, isStore, isMul;	// Unflushed op kinds
	logic memWait, mulWait;	// Stall reasons
	logic faultNow;
	exState stateQ;	// Last cycle's wait reason

	assign isLoad = (ex3Cmd == LOAD) && !opBraFlush;
	assign isStore = (ex3Cmd == STORE) && !opBraFlush;
	assign isMul = (ex3Cmd == MUL) && !opBraFlush;	// Flush drops the hold

	assign memReq = isLoad || isStore;
	assign memWrite = isStore;
	assign memAddr = ex3Addr;
	assign memWData = ex3StoreData;

	assign memWait = memReq && (memStatus == memBusy);
	assign faultNow = memReq && (memStatus == memFault);	// Retires, no stall
	assign memFaultSeen = faultNow;
	assign mulWait = isMul && (holdCnt < holdMax);
	assign exHold = memWait || mulWait;

	// Default forward, then substitute or discard
	always_comb begin
		wbId = ex3Id;
		wbVal = ex3Val;
		if (isLoad)
			wbVal = memRData;
		if (isMul)
			wbVal = mulRes;
		if (ex3Cmd == NOP || ex3Cmd == STORE || faultNow || opBraFlush)
			wbId = zeroReg;	// Nothing to write
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			holdCnt <= '0;
			stateQ <= IDLEPASS;
		end else begin
			if (!exHold)
				holdCnt <= '0;	// Op retired this cycle
			else if (holdCnt != holdMax)
				holdCnt <= holdCnt + 1'b1;
			stateQ <= memWait ? MEMWAIT : (mulWait ? MULWAIT : IDLEPASS);
		end
	end

	noHoldOnNop: assert property (@(posedge clock) disable iff (!rstN)
		exHold |-> (ex3Cmd != NOP))
		else $error("EX3 stall raised on a bubble");

	faultNoWrite: assert property (@(posedge clock) disable iff (!rstN)
		memFaultSeen |-> (wbId == zeroReg))
		else $error("EX3 writes back on a memory fault");

	cntBounded: assert property (@(posedge clock) disable iff (!rstN)
		holdCnt <= holdMax)
		else $error("EX3 hold counter past limit");

	// Stages are frozen, so a continuing multiply wait is still the same MUL
	mulWaitSticks: assert property (@(posedge clock) disable iff (!rstN)
		(stateQ == MULWAIT && exHold) |-> (ex3Cmd == MUL))
		else $error("EX3 multiply wait lost its MUL");

endmodule

// ==== hdl/exTop.sv ====
/* Execute back end EX1..EX3. No new op is taken while exHold is high and the
   source must keep its inputs steady then; mulHoldCycles must be at least 1 */
`timescale 1ns/10ps

module exTop import exPkg::*; #(
	parameter int mulHoldCycles = 2	// EX3 cycles held per MUL
) (
	input logic clock,
	input logic rstN,
	input logic opValid,
	input uCmd opCmd,
	input regVal srcA,
	input regVal srcB,
	input regVal imm,
	input regId dstId,
	input logic opBraFlush,	// Kills the op in EX3
	input memStat memStatus,
	input regVal memRData,
	output logic exHold,
	output regId wbId,
	output regVal wbVal,
	output logic memReq,
	output logic memWrite,
	output memAddrT memAddr,
	output regVal memWData,
	output logic memFaultSeen
);

	uCmd ex2Cmd, ex3Cmd;
	regId ex2Id, ex3Id;
	regVal ex2Val, ex3Val;
	memAddrT ex2Addr, ex3Addr;
	regVal ex2SrcA, ex2SrcB;
	regVal ex3StoreData;
	regVal mulRes;
	logic mulStart;

	assign mulStart = (ex2Cmd == MUL);	// Multiplier launches from EX2

	exStage1 stage1Inst (
		.clock(clock), .rstN(rstN), .hold(exHold),
		.opValid(opValid), .opCmd(opCmd), .srcA(srcA), .srcB(srcB),
		.imm(imm), .dstId(dstId),
		.ex2Cmd(ex2Cmd), .ex2Id(ex2Id), .ex2Val(ex2Val), .ex2Addr(ex2Addr),
		.ex2SrcA(ex2SrcA), .ex2SrcB(ex2SrcB)
	);

	exStage2 stage2Inst (
		.clock(clock), .rstN(rstN), .hold(exHold),
		.ex2Cmd(ex2Cmd), .ex2Id(ex2Id), .ex2Val(ex2Val), .ex2Addr(ex2Addr),
		.ex2SrcA(ex2SrcA), .ex2SrcB(ex2SrcB),
		.ex3Cmd(ex3Cmd), .ex3Id(ex3Id), .ex3Val(ex3Val), .ex3Addr(ex3Addr),
		.ex3StoreData(ex3StoreData)
	);

	exMulUnit #(.mulHoldCycles(mulHoldCycles)) mulInst (
		.clock(clock), .rstN(rstN), .hold(exHold), .mulStart(mulStart),
		.srcA(ex2SrcA), .srcB(ex2SrcB), .mulRes(mulRes)
	);

	exStage3 #(.mulHoldCycles(mulHoldCycles)) stage3Inst (
		.clock(clock), .rstN(rstN),
		.ex3Cmd(ex3Cmd), .ex3Id(ex3Id), .ex3Val(ex3Val), .ex3Addr(ex3Addr),
		.ex3StoreData(ex3StoreData), .mulRes(mulRes), .opBraFlush(opBraFlush),
		.memStatus(memStatus), .memRData(memRData),
		.exHold(exHold), .wbId(wbId), .wbVal(wbVal),
		.memReq(memReq), .memWrite(memWrite), .memAddr(memAddr),
		.memWData(memWData), .memFaultSeen(memFaultSeen)
	);

endmodule

// ==== verification/exTbTable.svh ====
/* Stimulus rows with expected writeback. A busy of -1 draws 0..3 busy cycles.
   Load data is the address XOR a fixed key */
`ifndef EX_TB_TABLE_SVH
`define EX_TB_TABLE_SVH

typedef struct packed {
	uCmd cmd;
	regVal a, b, imm;	// Sources and immediate
	regId dst;
	logic flush;	// Killed in EX3
	int busy;	// Memory busy cycles
	logic fault;	// Memory ends in a fault
	regId expId;
	regVal expVal;	// Only checked for a real write
} stimRow;

localparam int numRows = 16;

// Memory content is a function of the whole address
function automatic regVal loadData(memAddrT addr);
	return {16'h0, addr} ^ 64'h5A5A_0000_C3C3_0F0F;
endfunction

// cmd, a, b, imm, dst, flush, busy, fault, expId, expVal
stimRow rowTab [numRows] = '{
	'{ADD, 64'h10, 64'h22, 64'h0, 5'd1, 1'b0, 0, 1'b0, 5'd1, 64'h32},
	'{SUB, 64'h10, 64'h11, 64'h0, 5'd2, 1'b0, 0, 1'b0, 5'd2, 64'hFFFFFFFFFFFFFFFF},
	'{XOR, 64'hFF00, 64'h0FF0, 64'h0, 5'd3, 1'b0, 0, 1'b0, 5'd3, 64'hF0F0},
	'{SHL, 64'h1, 64'h3F, 64'h0, 5'd4, 1'b0, 0, 1'b0, 5'd4, 64'h8000000000000000},
	'{SHR, 64'h8000000000000000, 64'h4, 64'h0, 5'd5, 1'b0, 0, 1'b0, 5'd5,
		64'h0800000000000000},
	'{NOP, 64'h1, 64'h2, 64'h0, 5'd6, 1'b0, 0, 1'b0, 5'd0, 64'h0},
	'{MUL, 64'hFFFFFFFF00000003, 64'h100000005, 64'h0, 5'd7, 1'b0, 0, 1'b0, 5'd7, 64'hF},
	'{MUL, 64'hFFFFFFFF, 64'hFFFFFFFF, 64'h0, 5'd8, 1'b0, 0, 1'b0, 5'd8,
		64'hFFFFFFFE00000001},
	'{LOAD, 64'h1000, 64'h0, 64'h20, 5'd9, 1'b0, -1, 1'b0, 5'd9, 64'h5A5A0000C3C31F2F},
	'{STORE, 64'h2000, 64'hDEAD, 64'h8, 5'd10, 1'b0, 1, 1'b0, 5'd0, 64'h0},
	'{LOAD, 64'h3000, 64'h0, 64'h0, 5'd11, 1'b0, 2, 1'b1, 5'd0, 64'h0},
	'{AND, 64'hF0F0, 64'h0FF0, 64'h0, 5'd12, 1'b0, 0, 1'b0, 5'd12, 64'hF0},
	'{LOAD, 64'h4000, 64'h0, 64'h4, 5'd13, 1'b1, 0, 1'b0, 5'd0, 64'h0},
	'{MUL, 64'h7, 64'h9, 64'h0, 5'd14, 1'b1, 0, 1'b0, 5'd0, 64'h0},
	'{OR, 64'hF000, 64'h000F, 64'h0, 5'd15, 1'b1, 0, 1'b0, 5'd0, 64'h0},
	'{LOAD, 64'h100, 64'h0, 64'h10, 5'd16, 1'b0, -1, 1'b0, 5'd16, 64'h5A5A0000C3C30E1F}
};

`endif

// ==== verification/exTb.sv ====
/* Table-driven testbench for exTop with mulHoldCycles 2. The memory model answers
   after each row's busy count and the run stops at the first mismatch */
`timescale 1ns/10ps

module exTb import exPkg::*; ();

	`include "exTbTable.svh"

	localparam int mulHold = 2;
	localparam int limitNs = (numRows * (mulHold + 3 + 4) + 10) * 100;	// Max busy is 3

	logic clock = 1'b0;
	logic rstN = 1'b0;
	logic opValid = 1'b0;
	uCmd opCmd = NOP;
	regVal srcA = '0;
	regVal srcB = '0;
	regVal imm = '0;
	regId dstId = zeroReg;
	logic opBraFlush = 1'b0;
	memStat memStatus = memReady;
	regVal memRData, wbVal, memWData;
	regId wbId;
	memAddrT memAddr;
	logic exHold, memReq, memWrite, memFaultSeen;
	int seed = 42968;
	int curRow = -1;	// Row on the inputs
	int ex2Row = -1;
	int ex3Row = -1;	// Row now in EX3
	int busyLeft = 0;
	int holdSeen = 0;
	int expHold = 0;	// Hold cycles owed by the EX3 row
	int doneCount = 0;
	logic wasHeld = 1'b0;	// exHold at the last falling edge

	always #50 clock = ~clock;
	assign memRData = loadData(memAddr);	// Data rule of the memory

	exTop #(.mulHoldCycles(mulHold)) exTop_inst (.*);

	task automatic stopOnFailure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic compareId(regId got, regId exp, int row);
		if (got !== exp) begin
			$display("ERR %0t: row %0d wbId %0d, expected %0d", $time, row, got, exp);
			stopOnFailure();
		end
	endtask

	task automatic compareVal(regVal got, regVal exp, int row, string what);
		if (got !== exp) begin
			$display("ERR %0t: row %0d %s %h, expected %h", $time, row, what, got, exp);
			stopOnFailure();
		end
	endtask

	task automatic compareAddr(memAddrT got, memAddrT exp, int row);
		if (got !== exp) begin
			$display("ERR %0t: row %0d memAddr %h, expected %h", $time, row, got, exp);
			stopOnFailure();
		end
	endtask

	task automatic compareCount(int got, int exp, int row);
		if (got != exp) begin
			$display("ERR %0t: row %0d held %0d cycles, expected %0d", $time, row, got, exp);
			stopOnFailure();
		end
	endtask

	// Follows the rows into EX2 and EX3 and plays the memory
	always @(posedge clock) begin
		stimRow s;
		if (rstN && !wasHeld) begin
			ex3Row = ex2Row;	// Unheld edge moves the pipe
			ex2Row = curRow;
			busyLeft = 0;
			expHold = 0;
			if (ex3Row >= 0) begin
				s = rowTab[ex3Row];
				if (s.cmd == LOAD || s.cmd == STORE)
					busyLeft = (s.busy < 0) ? int'($unsigned($random(seed)) % 4) : s.busy;
				if (s.flush)
					busyLeft = 0;	// Memory never sees it
				expHold = (s.cmd == MUL && !s.flush) ? mulHold : busyLeft;
			end
		end else if (busyLeft > 0)
			busyLeft--;
		opBraFlush <= (ex3Row >= 0) && rowTab[ex3Row].flush;
		if (busyLeft > 0)
			memStatus <= memBusy;
		else if (ex3Row >= 0 && rowTab[ex3Row].fault)
			memStatus <= memFault;
		else
			memStatus <= memReady;
	end

	// Checks the EX3 row once exHold is low
	always @(negedge clock) begin
		stimRow s;
		logic memOp;
		wasHeld = exHold;
		if (rstN && ex3Row < 0) begin
			compareId(wbId, zeroReg, -1);	// Bubble writes nothing
			if (exHold || memReq || memWrite || memFaultSeen) begin
				$display("EX3 is empty but exHold, memReq, memWrite or memFaultSeen is high");
				stopOnFailure();
			end
		end else if (rstN && exHold) begin
			holdSeen++;
		end else if (rstN) begin
			s = rowTab[ex3Row];
			memOp = (s.cmd == LOAD || s.cmd == STORE) && !s.flush;
			compareId(wbId, s.expId, ex3Row);
			if (s.expId != zeroReg)
				compareVal(wbVal, s.expVal, ex3Row, "wbVal");
			compareCount(holdSeen, expHold, ex3Row);
			if (memFaultSeen !== (s.fault && !s.flush)) begin
				$display("memFaultSeen did not pulse as expected on row %0d", ex3Row);
				stopOnFailure();
			end
			if (memReq !== memOp) begin
				$display("memReq did not follow the memory access of row %0d", ex3Row);
				stopOnFailure();
			end
			if (memWrite !== (memOp && s.cmd == STORE)) begin
				$display("memWrite did not follow the store of row %0d", ex3Row);
				stopOnFailure();
			end
			if (memOp)
				compareAddr(memAddr, memAddrT'(s.a + s.imm), ex3Row);
			if (memOp && s.cmd == STORE)
				compareVal(memWData, s.b, ex3Row, "memWData");
			holdSeen = 0;
			doneCount++;
		end
	end

	initial begin
		repeat (3) @(posedge clock);
		rstN <= 1'b1;
		for (int i = 0; i < numRows; i++) begin
			@(posedge clock);
			opValid <= rowTab[i].cmd != NOP;	// NOP rows go in as empty slots
			opCmd <= rowTab[i].cmd;
			srcA <= rowTab[i].a;
			srcB <= rowTab[i].b;
			imm <= rowTab[i].imm;
			dstId <= rowTab[i].dst;
			curRow <= i;
			@(negedge clock);
			while (exHold)
				@(negedge clock);	// Inputs stay put while held
		end
		@(posedge clock);
		opValid <= 1'b0;
		opCmd <= NOP;
		curRow <= -1;
		wait (doneCount == numRows);
		@(posedge clock);
		$display("Simulation passed");
		$finish;
	end

	initial begin
		#(limitNs);
		$display("Timeout after %0d ns with %0d rows retired", limitNs, doneCount);
		stopOnFailure();
	end

endmodule
